//--- design/io_cfg.svh
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// ---------------------------------------------------------------------------
// Register map, word-aligned byte offsets
// ---------------------------------------------------------------------------

// Writable registers, core side
`define CR_SEG7_0            32'h0000_0000
`define CR_SEG7_1            32'h0000_0004
`define CR_SEG7_2            32'h0000_0008
`define CR_SEG7_3            32'h0000_000C
`define CR_SEG7_4            32'h0000_0010
`define CR_SEG7_5            32'h0000_0014
`define CR_LED               32'h0000_0018
`define CR_KBD_SCANF_EN      32'h0000_001C

// Read-only registers, sampled from the board
`define CR_BUTTON_0          32'h0000_0020
`define CR_BUTTON_1          32'h0000_0024
`define CR_SWITCH            32'h0000_0028
`define CR_JOYSTICK_X        32'h0000_002C
`define CR_JOYSTICK_Y        32'h0000_0030
// Keyboard queue status and head
`define CR_KBD_READY         32'h0000_0034
`define CR_KBD_DATA          32'h0000_0038
// VGA beam position
`define CR_VGA_COUNTER_X     32'h0000_003C
`define CR_VGA_COUNTER_Y     32'h0000_0040

// ---------------------------------------------------------------------------
// Sizes
// ---------------------------------------------------------------------------

// Seven-segment digits on the board
`define IO_SEG7_NUM          6
// Scan codes held by the keyboard queue
`define IO_KBD_DEPTH         8

// Blank flag inside a digit register
`define IO_DIGIT_BLANK_BIT   4
// Digit register value after reset, digit dark
`define IO_DIGIT_BLANK       8'h10

`endif

//--- design/io_pkg.sv
`include "io_cfg.svh"

package io_pkg;

// ---------------------------------------------------------------------------
// Plain vector types
// ---------------------------------------------------------------------------

// Core and fabric bus
typedef logic [31:0] t_cr_addr;
typedef logic [31:0] t_cr_data;

// Digit register
// Low nibble holds the hex value, bit 4 blanks the digit
typedef logic [7:0] t_hex_digit;

// Segments a..g in bits 0..6, active low
typedef logic [6:0] t_seg7_pins;

// PS/2 scan code
typedef logic [7:0] t_kbd_code;

// VGA beam counter
typedef logic [9:0] t_vga_count;

// ---------------------------------------------------------------------------
// Board side bundles
// ---------------------------------------------------------------------------

// Raw inputs from the board, asynchronous to Clk
typedef struct packed {
    logic        button_0;
    logic        button_1;
    logic [9:0]  switch;
    logic [11:0] joystick_x;
    logic [11:0] joystick_y;
} t_fpga_in;

// Writable output registers
typedef struct packed {
    t_hex_digit [`IO_SEG7_NUM-1:0] seg7;
    logic [9:0]                    led;
} t_fpga_out;

// ---------------------------------------------------------------------------
// Keyboard queue bundles
// ---------------------------------------------------------------------------

// Queue toward the register file
// Head code and a non-empty flag
typedef struct packed {
    logic      kbd_ready;
    t_kbd_code kbd_data;
} t_kbd_data_rd;

// Register file toward the queue
typedef struct packed {
    // Head removal, one per core data read
    logic kbd_pop;
    // Capture gate for incoming codes
    logic kbd_scanf_en;
} t_kbd_ctrl;

endpackage

//--- design/cr_mem.sv
`timescale 1ns/10ps
`include "io_cfg.svh"

module cr_mem
    import io_pkg::*;
(
    input  logic             Clk,
    input  logic             rst,
    // Core port, read and write
    input  t_cr_addr         address,
    input  t_cr_data         data,
    input  logic             wren,
    input  logic             rden,
    output t_cr_data         q,
    // Fabric port, read only, no enable
    input  t_cr_addr         address_b,
    output t_cr_data         q_b,
    // Board inputs
    input  var t_fpga_in     fpga_in,
    input  t_vga_count       vga_counter_x,
    input  t_vga_count       vga_counter_y,
    // Keyboard queue
    input  var t_kbd_data_rd kbd_data_rd,
    output t_kbd_ctrl        kbd_ctrl,
    // Toward the pins
    output t_fpga_out        fpga_out
);

// LEDs off, every digit blanked
localparam t_fpga_out OUT_RESET = '{
    seg7: {`IO_SEG7_NUM{`IO_DIGIT_BLANK}},
    led:  '0
};

// Writable registers and next state
t_fpga_out  cr_out;
t_fpga_out  cr_out_next;
logic       scanf_en;
logic       scanf_en_next;

// First output pipeline flop, second one is fpga_out
t_fpga_out  out_pipe_1;

// Two-flop synchronizer on the board inputs
t_fpga_in   in_sync_1;
t_fpga_in   in_sync_2;

// Sampled VGA counters
t_vga_count vga_x_q;
t_vga_count vga_y_q;

// Read words before the output flops
t_cr_data   pre_q;
t_cr_data   pre_q_b;

// ---------------------------------------------------------------------------
// Core write decode
// ---------------------------------------------------------------------------

always_comb begin
    cr_out_next   = cr_out;
    scanf_en_next = scanf_en;
    if (wren) begin
        case (address)
            `CR_SEG7_0       : cr_out_next.seg7[0] = data[7:0];
            `CR_SEG7_1       : cr_out_next.seg7[1] = data[7:0];
            `CR_SEG7_2       : cr_out_next.seg7[2] = data[7:0];
            `CR_SEG7_3       : cr_out_next.seg7[3] = data[7:0];
            `CR_SEG7_4       : cr_out_next.seg7[4] = data[7:0];
            `CR_SEG7_5       : cr_out_next.seg7[5] = data[7:0];
            `CR_LED          : cr_out_next.led     = data[9:0];
            `CR_KBD_SCANF_EN : scanf_en_next       = data[0];
            // Read-only or unmapped, write dropped
            default          : ;
        endcase
    end
end

// Control registers and output pipeline
// Register, then two flops before the encoders and LEDs
always_ff @(posedge Clk) begin
    if (rst) begin
        cr_out     <= OUT_RESET;
        out_pipe_1 <= OUT_RESET;
        fpga_out   <= OUT_RESET;
        scanf_en   <= 1'b0;
    end else begin
        cr_out     <= cr_out_next;
        out_pipe_1 <= cr_out;
        fpga_out   <= out_pipe_1;
        scanf_en   <= scanf_en_next;
    end
end

// ---------------------------------------------------------------------------
// Input sampling
// ---------------------------------------------------------------------------

always_ff @(posedge Clk) begin
    in_sync_1 <= fpga_in;
    in_sync_2 <= in_sync_1;
    // Counters come from the same clock domain, one flop is enough
    vga_x_q   <= vga_counter_x;
    vga_y_q   <= vga_counter_y;
end

// ---------------------------------------------------------------------------
// Read mux
// ---------------------------------------------------------------------------

// Shared by both ports
// Fields zero-extended, unmapped offsets read zero
function automatic t_cr_data read_word(input t_cr_addr addr);
    t_cr_data word;
    word = '0;
    case (addr)
        `CR_SEG7_0        : word = {24'b0, cr_out.seg7[0]};
        `CR_SEG7_1        : word = {24'b0, cr_out.seg7[1]};
        `CR_SEG7_2        : word = {24'b0, cr_out.seg7[2]};
        `CR_SEG7_3        : word = {24'b0, cr_out.seg7[3]};
        `CR_SEG7_4        : word = {24'b0, cr_out.seg7[4]};
        `CR_SEG7_5        : word = {24'b0, cr_out.seg7[5]};
        `CR_LED           : word = {22'b0, cr_out.led};
        `CR_KBD_SCANF_EN  : word = {31'b0, scanf_en};
        `CR_BUTTON_0      : word = {31'b0, in_sync_2.button_0};
        `CR_BUTTON_1      : word = {31'b0, in_sync_2.button_1};
        `CR_SWITCH        : word = {22'b0, in_sync_2.switch};
        `CR_JOYSTICK_X    : word = {20'b0, in_sync_2.joystick_x};
        `CR_JOYSTICK_Y    : word = {20'b0, in_sync_2.joystick_y};
        // Head before any pop on this edge
        `CR_KBD_READY     : word = {31'b0, kbd_data_rd.kbd_ready};
        `CR_KBD_DATA      : word = {24'b0, kbd_data_rd.kbd_data};
        `CR_VGA_COUNTER_X : word = {22'b0, vga_x_q};
        `CR_VGA_COUNTER_Y : word = {22'b0, vga_y_q};
        default           : word = '0;
    endcase
    return word;
endfunction

always_comb begin
    // Core word gated by rden
    pre_q   = rden ? read_word(address) : '0;
    // Fabric reads every cycle
    pre_q_b = read_word(address_b);
end

// One cycle read latency on both ports
always_ff @(posedge Clk) begin
    if (rst) begin
        q   <= '0;
        q_b <= '0;
    end else begin
        q   <= pre_q;
        q_b <= pre_q_b;
    end
end

// ---------------------------------------------------------------------------
// Keyboard control
// ---------------------------------------------------------------------------

// Pop only from the core port, fabric reads leave the queue alone
assign kbd_ctrl.kbd_pop      = rden && (address == `CR_KBD_DATA);
assign kbd_ctrl.kbd_scanf_en = scanf_en;

endmodule

//--- design/kbd_fifo.sv
`timescale 1ns/10ps
`include "io_cfg.svh"

module kbd_fifo
    import io_pkg::*;
(
    input  logic          Clk,
    input  logic          rst,
    // Incoming scan codes
    input  logic          kbd_valid,
    input  t_kbd_code     kbd_code,
    // Gate and pop from the register file
    input  var t_kbd_ctrl kbd_ctrl,
    // Head and ready flag
    output t_kbd_data_rd  kbd_data_rd
);

localparam int DEPTH = `IO_KBD_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

// Code storage
t_kbd_code        mem [DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;

logic             full;
logic             empty;
logic             push;
logic             pop;

// Wrap at DEPTH, also for depths that are not a power of two
function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign full  = (count == CNT_W'(DEPTH));
assign empty = (count == '0);

// Codes dropped while scan is off or the queue is full
assign push  = kbd_valid && kbd_ctrl.kbd_scanf_en && !full;
// Pop on empty ignored
assign pop   = kbd_ctrl.kbd_pop && !empty;

always_ff @(posedge Clk) begin
    if (push) begin
        mem[wr_ptr] <= kbd_code;
    end
end

always_ff @(posedge Clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
        if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
        // Push and pop together keep the count
        case ({push, pop})
            2'b10   : count <= count + 1'b1;
            2'b01   : count <= count - 1'b1;
            default : ;
        endcase
    end
end

// Head presented straight from storage, zero when empty
assign kbd_data_rd.kbd_ready = !empty;
assign kbd_data_rd.kbd_data  = empty ? '0 : mem[rd_ptr];

endmodule

//--- design/seg7_encoder.sv
`timescale 1ns/10ps
`include "io_cfg.svh"

module seg7_encoder
    import io_pkg::*;
(
    input  t_hex_digit digit,
    output t_seg7_pins pins
);

// Lit pattern for the value nibble
t_seg7_pins pattern;

// Bit order g f e d c b a, 0 lights a segment
always_comb begin
    case (digit[3:0])
        4'h0    : pattern = 7'b100_0000;
        4'h1    : pattern = 7'b111_1001;
        4'h2    : pattern = 7'b010_0100;
        4'h3    : pattern = 7'b011_0000;
        4'h4    : pattern = 7'b001_1001;
        4'h5    : pattern = 7'b001_0010;
        4'h6    : pattern = 7'b000_0010;
        4'h7    : pattern = 7'b111_1000;
        4'h8    : pattern = 7'b000_0000;
        4'h9    : pattern = 7'b001_0000;
        4'hA    : pattern = 7'b000_1000;
        // Lower case b and d, upper case C E F
        4'hB    : pattern = 7'b000_0011;
        4'hC    : pattern = 7'b100_0110;
        4'hD    : pattern = 7'b010_0001;
        4'hE    : pattern = 7'b000_0110;
        default : pattern = 7'b000_1110;
    endcase
end

// Blank bit turns every segment off
assign pins = digit[`IO_DIGIT_BLANK_BIT] ? '1 : pattern;

endmodule

//--- design/io_ctrl_top.sv
`timescale 1ns/10ps
`include "io_cfg.svh"

module io_ctrl_top
    import io_pkg::*;
(
    input  logic                          Clk,
    input  logic                          rst,
    // Core port
    input  t_cr_addr                      address,
    input  t_cr_data                      data,
    input  logic                          wren,
    input  logic                          rden,
    output t_cr_data                      q,
    // Fabric port
    input  t_cr_addr                      address_b,
    output t_cr_data                      q_b,
    // Board inputs
    input  var t_fpga_in                  fpga_in,
    input  t_vga_count                    vga_counter_x,
    input  t_vga_count                    vga_counter_y,
    // Keyboard source
    input  logic                          kbd_valid,
    input  t_kbd_code                     kbd_code,
    // Board outputs
    output logic [9:0]                    led,
    output t_seg7_pins [`IO_SEG7_NUM-1:0] seg7
);

// Queue handshake
t_kbd_ctrl    kbd_ctrl;
t_kbd_data_rd kbd_data_rd;

// Pipelined register outputs
t_fpga_out    fpga_out;

// ---------------------------------------------------------------------------
// Register file
// ---------------------------------------------------------------------------

cr_mem u_cr_mem (
    .Clk           (Clk),
    .rst           (rst),
    .address       (address),
    .data          (data),
    .wren          (wren),
    .rden          (rden),
    .q             (q),
    .address_b     (address_b),
    .q_b           (q_b),
    .fpga_in       (fpga_in),
    .vga_counter_x (vga_counter_x),
    .vga_counter_y (vga_counter_y),
    .kbd_data_rd   (kbd_data_rd),
    .kbd_ctrl      (kbd_ctrl),
    .fpga_out      (fpga_out)
);

// Scan-code queue
kbd_fifo u_kbd_fifo (
    .Clk         (Clk),
    .rst         (rst),
    .kbd_valid   (kbd_valid),
    .kbd_code    (kbd_code),
    .kbd_ctrl    (kbd_ctrl),
    .kbd_data_rd (kbd_data_rd)
);

// ---------------------------------------------------------------------------
// Pins
// ---------------------------------------------------------------------------

assign led = fpga_out.led;

// One encoder per digit
for (genvar i = 0; i < `IO_SEG7_NUM; i++) begin : g_seg7
    seg7_encoder u_seg7_encoder (
        .digit (fpga_out.seg7[i]),
        .pins  (seg7[i])
    );
end

endmodule

//--- verification/io_ctrl_properties.sv
`timescale 1ns/10ps

module io_ctrl_properties
    import io_pkg::*;
(
    input logic          Clk,
    input logic          rst,
    input logic          rden,
    input t_cr_data      q,
    input var t_kbd_ctrl kbd_ctrl,
    input var t_fpga_out fpga_out
);

// Idle core port returns zero one cycle later
a_q_zero_idle : assert property (
    @(posedge Clk) disable iff (rst) !rden |=> (q == '0)
) else $error("q not zero after a cycle with rden low");

// Queue pops come only from core reads
a_pop_needs_rden : assert property (
    @(posedge Clk) disable iff (rst) kbd_ctrl.kbd_pop |-> rden
) else $error("kbd_pop raised without rden");

// Reset clears the LED stage
a_led_reset : assert property (
    @(posedge Clk) rst |=> (fpga_out.led == '0)
) else $error("led not cleared by reset");

endmodule

bind cr_mem io_ctrl_properties u_io_ctrl_properties (.*);

//--- verification/io_ctrl_tb.sv
`timescale 1ns/10ps
`include "io_cfg.svh"

module io_ctrl_tb
    import io_pkg::*;
();

localparam int HALF_PERIOD = 20;
// Twice the roughly 140 cycles that all tests take together
localparam int TIMEOUT_CYCLES = 300;

logic                          Clk;
logic                          rst;
t_cr_addr                      address;
t_cr_data                      data;
logic                          wren;
logic                          rden;
t_cr_data                      q;
t_cr_addr                      address_b;
t_cr_data                      q_b;
t_fpga_in                      fpga_in;
t_vga_count                    vga_counter_x;
t_vga_count                    vga_counter_y;
logic                          kbd_valid;
t_kbd_code                     kbd_code;
logic [9:0]                    led;
t_seg7_pins [`IO_SEG7_NUM-1:0] seg7;

// Xorshift state
logic [31:0] rng_state;
int          cycle_count = 0;

io_ctrl_top UUT (.*);

initial begin
    Clk = 1'b0;
    forever #HALF_PERIOD Clk = ~Clk;
end

// Cycle limit on the whole run
always @(posedge Clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $fatal(1, "run stopped by the cycle limit");
    end
end

// ---------------------------------------------------------------------------
// Helpers
// ---------------------------------------------------------------------------

// 32-bit xorshift
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Common hex font with segments a..g lit high
// Inverted at the end for the active-low pins
function automatic t_seg7_pins seg_pattern(input t_hex_digit d);
    logic [6:0] lit;
    case (d[3:0])
        4'h0    : lit = 7'h3F;
        4'h1    : lit = 7'h06;
        4'h2    : lit = 7'h5B;
        4'h3    : lit = 7'h4F;
        4'h4    : lit = 7'h66;
        4'h5    : lit = 7'h6D;
        4'h6    : lit = 7'h7D;
        4'h7    : lit = 7'h07;
        4'h8    : lit = 7'h7F;
        4'h9    : lit = 7'h6F;
        4'hA    : lit = 7'h77;
        4'hB    : lit = 7'h7C;
        4'hC    : lit = 7'h39;
        4'hD    : lit = 7'h5E;
        4'hE    : lit = 7'h79;
        default : lit = 7'h71;
    endcase
    // Nothing lit on a blanked digit
    if (d[`IO_DIGIT_BLANK_BIT])
        lit = '0;
    return ~lit;
endfunction

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
        $display("Test FAILED");
        $fatal(1, "mismatch");
    end
endtask

// All bus tasks start and end on a falling edge
task automatic wait_cycles(input int n);
    repeat (n) @(negedge Clk);
endtask

// Single-cycle write strobe
task automatic write_reg(input t_cr_addr addr, input t_cr_data value);
    address = addr;
    data    = value;
    wren    = 1'b1;
    @(negedge Clk);
    wren    = 1'b0;
endtask

// Same offset on both ports with a selectable core enable
task automatic read_reg(input t_cr_addr addr, input logic en,
                        output t_cr_data core_q, output t_cr_data fabric_q);
    address   = addr;
    address_b = addr;
    rden      = en;
    @(negedge Clk);
    rden      = 1'b0;
    // Read data settled one edge after the enable
    core_q    = q;
    fabric_q  = q_b;
endtask

// Core and fabric read of one offset against one value
task automatic check_read(input t_cr_addr addr, input t_cr_data expected, input string what);
    t_cr_data core_q;
    t_cr_data fabric_q;
    read_reg(addr, 1'b1, core_q, fabric_q);
    check_value(core_q, expected, {what, " on core port"});
    check_value(fabric_q, expected, {what, " on fabric port"});
endtask

// One code with a one-cycle valid
task automatic push_code(input t_kbd_code code);
    kbd_valid = 1'b1;
    kbd_code  = code;
    @(negedge Clk);
    kbd_valid = 1'b0;
endtask

// ---------------------------------------------------------------------------
// Tests
// ---------------------------------------------------------------------------

task automatic test_reset_state();
    check_value({22'b0, led}, '0, "led after reset");
    for (int i = 0; i < `IO_SEG7_NUM; i++)
        check_value({25'b0, seg7[i]}, 32'h7F, "seg7 dark after reset");
    check_read(`CR_KBD_READY, '0, "kbd ready after reset");
    check_read(`CR_KBD_SCANF_EN, '0, "scan enable after reset");
endtask

task automatic test_output_regs();
    logic [31:0] r;
    t_hex_digit  digits [`IO_SEG7_NUM];
    logic [9:0]  led_val;
    repeat (3) begin
        for (int i = 0; i < `IO_SEG7_NUM; i++) begin
            r = next_rand();
            digits[i] = r[7:0];
            write_reg(`CR_SEG7_0 + 32'(4 * i), r);
        end
        // LED written last so the pins are checked three edges after it
        r = next_rand();
        led_val = r[9:0];
        write_reg(`CR_LED, r);
        wait_cycles(2);
        check_value({22'b0, led}, {22'b0, led_val}, "led pins");
        for (int i = 0; i < `IO_SEG7_NUM; i++)
            check_value({25'b0, seg7[i]}, {25'b0, seg_pattern(digits[i])}, "seg7 pins");
        for (int i = 0; i < `IO_SEG7_NUM; i++)
            check_read(`CR_SEG7_0 + 32'(4 * i), {24'b0, digits[i]}, "digit readback");
        check_read(`CR_LED, {22'b0, led_val}, "led readback");
    end
endtask

task automatic test_input_regs();
    logic [31:0] r;
    logic [31:0] j;
    logic [31:0] v;
    repeat (3) begin
        r = next_rand();
        j = next_rand();
        v = next_rand();
        fpga_in = '{button_0: r[0], button_1: r[1], switch: r[11:2],
                    joystick_x: j[11:0], joystick_y: j[27:16]};
        vga_counter_x = v[9:0];
        vga_counter_y = v[25:16];
        // Two synchronizer edges here and the third one in the read
        wait_cycles(2);
        check_read(`CR_BUTTON_0, {31'b0, r[0]}, "button 0");
        check_read(`CR_BUTTON_1, {31'b0, r[1]}, "button 1");
        check_read(`CR_SWITCH, {22'b0, r[11:2]}, "switches");
        check_read(`CR_JOYSTICK_X, {20'b0, j[11:0]}, "joystick x");
        check_read(`CR_JOYSTICK_Y, {20'b0, j[27:16]}, "joystick y");
        check_read(`CR_VGA_COUNTER_X, {22'b0, v[9:0]}, "vga counter x");
        check_read(`CR_VGA_COUNTER_Y, {22'b0, v[25:16]}, "vga counter y");
    end
endtask

// Push n codes with scan on and expect the first m in order
task automatic run_queue(input int n, input int m);
    logic [31:0] r;
    t_kbd_code   sent [$];
    for (int i = 0; i < n; i++) begin
        r = next_rand();
        sent.push_back(r[7:0]);
        push_code(r[7:0]);
    end
    // Each data read pops one code
    for (int i = 0; i < m; i++) begin
        check_read(`CR_KBD_READY, 32'd1, "kbd ready with codes queued");
        check_read(`CR_KBD_DATA, {24'b0, sent[i]}, "kbd code order");
    end
    check_read(`CR_KBD_READY, '0, "kbd ready after draining");
endtask

task automatic test_kbd_order();
    write_reg(`CR_KBD_SCANF_EN, '0);
    // Codes dropped while scan is off
    repeat (3) push_code(8'hA5);
    check_read(`CR_KBD_READY, '0, "kbd ready with scan off");
    write_reg(`CR_KBD_SCANF_EN, 32'd1);
    check_read(`CR_KBD_SCANF_EN, 32'd1, "scan enable readback");
    run_queue(5, 5);
endtask

// Two codes beyond the queue depth
task automatic test_kbd_overflow();
    run_queue(10, `IO_KBD_DEPTH);
    write_reg(`CR_KBD_SCANF_EN, '0);
endtask

task automatic test_unmapped();
    logic [31:0] r;
    logic [9:0]  led_val;
    t_cr_data    core_q;
    t_cr_data    fabric_q;
    // Known LED value to compare against after the stray writes
    r = next_rand();
    led_val = r[9:0];
    write_reg(`CR_LED, r);
    write_reg(32'h0000_0044, next_rand());
    write_reg(32'h0000_0101, next_rand());
    check_read(32'h0000_0044, '0, "unmapped offset 0x44");
    check_read(32'h0000_0101, '0, "unmapped offset 0x101");
    check_read(`CR_LED, {22'b0, led_val}, "led after unmapped writes");
    // Core reads zero without rden while the fabric still sees the register
    read_reg(`CR_LED, 1'b0, core_q, fabric_q);
    check_value(core_q, '0, "core read without rden");
    check_value(fabric_q, {22'b0, led_val}, "fabric read next to idle core");
endtask

// ---------------------------------------------------------------------------
// Main sequence
// ---------------------------------------------------------------------------

initial begin
    rng_state     = 32'd40088;
    rst           = 1'b1;
    address       = '0;
    data          = '0;
    wren          = 1'b0;
    rden          = 1'b0;
    address_b     = '0;
    fpga_in       = '0;
    vga_counter_x = '0;
    vga_counter_y = '0;
    kbd_valid     = 1'b0;
    kbd_code      = '0;
    repeat (3) @(posedge Clk);
    @(negedge Clk);
    rst = 1'b0;
    test_reset_state();
    test_output_regs();
    test_input_regs();
    test_kbd_order();
    test_kbd_overflow();
    test_unmapped();
    $display("Test OK");
    $finish;
end

endmodule

//--- sim.f
+incdir+design
design/io_pkg.sv
design/cr_mem.sv
design/kbd_fifo.sv
design/seg7_encoder.sv
design/io_ctrl_top.sv
verification/io_ctrl_properties.sv
verification/io_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the io_ctrl testbench

TOP := io_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sim.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
